/* tb/mmu_tests.txt */
# M addr data | F whole vpn
# T prv mprv mpp sum mode satp_ppn pmp_vlxwr w x va exp_pa exp_bad exp_ar
# root table at 100000, level 0 table at 101000
M 100004 00040401
M 100008 001000C7
M 10000C 80000001
M 100010 001004C7
M 101000 000800C7
M 101004 00080443
M 101008 000808D7
M 10100C 00080C87
M 101010 00081047
M 101018 000C0001
M 10101C 00081CC7
M 101020 000820C7
M 101024 000824C7
M 101028 000828C7
M 10102C 00082CC7
M 101030 000830C7
M 101034 000834C7
M 101038 000838C7
M 10103C 00083CC7
M 101040 000840C7
# bare translations
T 3 0 0 0 1 000100 10111 0 0 89ABCDEF 089ABCDEF 0 0
T 1 0 0 0 0 000100 10111 0 0 FEDCBA98 0FEDCBA98 0 0
T 3 1 1 0 1 000100 10111 0 1 00812345 000812345 0 0
# 4 KiB walk, hit, page and full flush
T 1 0 0 0 1 000100 10111 0 0 00400123 000200123 0 2
T 1 0 0 0 1 000100 10111 0 0 00400123 000200123 0 0
F 0 00400
T 1 0 0 0 1 000100 10111 0 0 00400123 000200123 0 2
T 3 1 1 0 1 000100 10111 0 0 00400456 000200456 0 0 # mprv gives S
F 1 00000
T 1 0 0 0 1 000100 10111 0 0 00400123 000200123 0 2
# megapage walk, hit, misaligned
T 1 0 0 0 1 000100 10111 0 0 00812345 000412345 0 1
T 1 0 0 0 1 000100 10111 1 0 00833000 000433000 0 0
T 1 0 0 0 1 000100 10111 0 0 01000000 000000000 1 1
# page faults
T 1 0 0 0 1 000100 10111 1 0 00401010 000000000 1 2
T 1 0 0 0 1 000100 10111 0 0 00401010 000201010 0 2
T 1 0 0 0 1 000100 10111 1 0 00401010 000000000 1 0
T 1 0 0 0 1 000100 10111 0 0 00402040 000000000 1 2
T 1 0 0 1 1 000100 10111 0 0 00402040 000202040 0 2
T 0 0 0 0 1 000100 10111 0 0 00402040 000202040 0 0
T 1 0 0 0 1 000100 10111 0 0 00403000 000000000 1 2
T 1 0 0 0 1 000100 10111 1 0 00404008 000000000 1 2
T 1 0 0 0 1 000100 10111 0 0 00404008 000204008 0 2
T 1 0 0 0 1 000100 10111 0 0 00405000 000000000 1 2
T 1 0 0 0 1 000100 10111 0 0 00406000 000000000 1 2
# access faults, pmp at refill then stored pmp on a hit, bus error
T 1 0 0 0 1 000100 10001 1 0 00407100 000207100 2 2
T 1 0 0 0 1 000100 10111 1 0 00407100 000207100 2 0
T 1 0 0 0 1 000100 10111 0 0 00C00000 000000000 2 2
# round robin eviction over nine pages
F 1 00000
T 1 0 0 0 1 000100 10111 0 0 00408000 000208000 0 2
T 1 0 0 0 1 000100 10111 0 0 00409000 000209000 0 2
T 1 0 0 0 1 000100 10111 0 0 0040A000 00020A000 0 2
T 1 0 0 0 1 000100 10111 0 0 0040B000 00020B000 0 2
T 1 0 0 0 1 000100 10111 0 0 0040C000 00020C000 0 2
T 1 0 0 0 1 000100 10111 0 0 0040D000 00020D000 0 2
T 1 0 0 0 1 000100 10111 0 0 0040E000 00020E000 0 2
T 1 0 0 0 1 000100 10111 0 0 0040F000 00020F000 0 2
T 1 0 0 0 1 000100 10111 0 0 00410000 000210000 0 2
T 1 0 0 0 1 000100 10111 0 0 00409000 000209000 0 0
T 1 0 0 0 1 000100 10111 0 0 00408000 000208000 0 2
T 1 0 0 0 1 000100 10111 0 0 00409000 000209000 0 2

/* verilog.f */
hdl/sv32_pkg.sv
hdl/tlb_pkg.sv
hdl/tlb_entry.sv
hdl/tlb_fill.sv
hdl/tlb_lookup.sv
hdl/mmu_walker.sv
hdl/mmu_top.sv
tb/mmu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module mmu_tb \
    -f verilog.f \
    -o mmu_sim

./obj_dir/mmu_sim

/* tb/mmu_tb.sv */
module mmu_tb;
    import sv32_pkg::*;
    import tlb_pkg::*;

    localparam int CYCLE_LIMIT = 200;

    logic       clk;
    logic       rstn;
    logic       va_valid;
    vaddr_t     va;
    logic       access_w;
    logic       access_x;
    prv_t       prv;
    logic       mprv;
    prv_t       mpp;
    logic       sum;
    logic       satp_mode;
    ppn_t       satp_ppn;
    logic       pmp_v;
    logic       pmp_l;
    logic       pmp_x;
    logic       pmp_w;
    logic       pmp_r;
    logic       tlb_flush_req;
    logic       tlb_flush_all;
    vpn_t       tlb_flush_vpn;
    logic       pa_valid;
    paddr_t     pa;
    bad_t       pa_bad;
    logic       busy;
    logic       m_arvalid;
    paddr_t     m_araddr;
    logic       m_arready;
    logic       m_rvalid;
    pte_t       m_rdata;
    logic [1:0] m_rresp;

    pte_t       mem [paddr_t]; // page table words from the data file
    int         ar_count;      // AR handshakes seen by the responder
    int         n_req;
    paddr_t     exp_pa;
    bad_t       exp_bad;
    int         exp_ar;

    mmu_top mmu_top_inst (
        .clk           (clk),
        .rstn          (rstn),
        .va_valid      (va_valid),
        .va            (va),
        .access_w      (access_w),
        .access_x      (access_x),
        .prv           (prv),
        .mprv          (mprv),
        .mpp           (mpp),
        .sum           (sum),
        .satp_mode     (satp_mode),
        .satp_ppn      (satp_ppn),
        .pmp_v         (pmp_v),
        .pmp_l         (pmp_l),
        .pmp_x         (pmp_x),
        .pmp_w         (pmp_w),
        .pmp_r         (pmp_r),
        .tlb_flush_req (tlb_flush_req),
        .tlb_flush_all (tlb_flush_all),
        .tlb_flush_vpn (tlb_flush_vpn),
        .pa_valid      (pa_valid),
        .pa            (pa),
        .pa_bad        (pa_bad),
        .busy          (busy),
        .m_arvalid     (m_arvalid),
        .m_araddr      (m_araddr),
        .m_arready     (m_arready),
        .m_rvalid      (m_rvalid),
        .m_rdata       (m_rdata),
        .m_rresp       (m_rresp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s (time %0t)", reason, $time);
        $display("ERRORS FOUND");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, what, got, expected);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != 'h0A && c != -1)
            c = $fgetc(fd);
    endtask

    // steps past the current edge, so a refill from the last answer is already written
    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy) begin
            if (n >= CYCLE_LIMIT)
                abort_run("timeout waiting for busy to fall");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic apply_flush(input logic whole, input vpn_t vpn);
        tlb_flush_all = whole;
        tlb_flush_vpn = vpn;
        tlb_flush_req = 1'b1;
        @(negedge clk);
        tlb_flush_req = 1'b0;
    endtask

    task automatic apply_request();
        int cycles;
        int ar_start;
        ar_start = ar_count;
        va_valid = 1'b1;
        @(negedge clk);
        va_valid = 1'b0;
        cycles   = 1;
        while (!pa_valid) begin
            check_value($sformatf("request %0d busy during walk", n_req), 64'(busy), 64'd1);
            if (cycles >= CYCLE_LIMIT)
                abort_run($sformatf("timeout waiting for pa_valid on request %0d", n_req));
            @(negedge clk);
            cycles++;
        end
        check_value($sformatf("request %0d pa", n_req), 64'(pa), 64'(exp_pa));
        check_value($sformatf("request %0d pa_bad", n_req), 64'(pa_bad), 64'(exp_bad));
        check_value($sformatf("request %0d AR count", n_req), 64'(ar_count - ar_start),
                    64'(exp_ar));
        check_value($sformatf("request %0d busy with pa_valid", n_req), 64'(busy), 64'd0);
        if (exp_ar == 0) // bare or hit answers in the next cycle
            check_value($sformatf("request %0d latency", n_req), 64'(cycles), 64'd1);
    endtask

    // AXI read slave, random ready and response delays
    initial begin
        int     ar_delay;
        int     r_delay;
        logic   pending;
        paddr_t rsp_addr;
        void'($urandom(41942));
        m_arready = 1'b0;
        m_rvalid  = 1'b0;
        m_rdata   = '0;
        m_rresp   = 2'b00;
        ar_count  = 0;
        pending   = 1'b0;
        r_delay   = 0;
        rsp_addr  = '0;
        ar_delay  = $urandom_range(3);
        forever begin
            @(negedge clk);
            m_arready = 1'b0;
            m_rvalid  = 1'b0;
            if (pending) begin
                if (r_delay == 0) begin
                    m_rvalid = 1'b1;
                    m_rdata  = mem.exists(rsp_addr) ? mem[rsp_addr] : '0; // absent is invalid
                    m_rresp  = rsp_addr[33] ? 2'b10 : 2'b00;
                    pending  = 1'b0;
                end else begin
                    r_delay--;
                end
            end else if (m_arvalid) begin
                if (ar_delay == 0) begin
                    m_arready = 1'b1; // handshake at the coming edge
                    rsp_addr  = m_araddr;
                    pending   = 1'b1;
                    ar_count++;
                    r_delay   = $urandom_range(3);
                    ar_delay  = $urandom_range(3);
                end else begin
                    ar_delay--;
                end
            end
        end
    end

    initial begin
        int         fd;
        int         n;
        logic [7:0] kind;
        paddr_t     m_addr;
        pte_t       m_data;
        pmp_bits_t  r_pmp;
        logic       r_whole;
        vpn_t       r_vpn;
        logic       done;
        rstn          = 1'b0;
        va_valid      = 1'b0;
        va            = '0;
        access_w      = 1'b0;
        access_x      = 1'b0;
        prv           = PRV_M;
        mprv          = 1'b0;
        mpp           = PRV_U;
        sum           = 1'b0;
        satp_mode     = SATP_MODE_BARE;
        satp_ppn      = '0;
        pmp_v         = 1'b0;
        pmp_l         = 1'b0;
        pmp_x         = 1'b0;
        pmp_w         = 1'b0;
        pmp_r         = 1'b0;
        tlb_flush_req = 1'b0;
        tlb_flush_all = 1'b0;
        tlb_flush_vpn = '0;
        n_req         = 0;
        exp_pa        = '0;
        exp_bad       = BAD_NONE;
        exp_ar        = 0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        check_value("pa_valid after reset", 64'(pa_valid), 64'd0);
        check_value("busy after reset", 64'(busy), 64'd0);
        check_value("m_arvalid after reset", 64'(m_arvalid), 64'd0);

        fd = $fopen("tb/mmu_tests.txt", "r");
        if (fd == 0)
            abort_run("cannot open tb/mmu_tests.txt");
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                skip_line(fd);
            end else if (kind == "M") begin
                n = $fscanf(fd, "%h %h", m_addr, m_data);
                if (n != 2)
                    abort_run("malformed memory record in data file");
                mem[m_addr] = m_data;
            end else if (kind == "T") begin
                wait_idle();
                n = $fscanf(fd, "%d %d %d %d %d %h %b %d %d %h %h %d %d",
                            prv, mprv, mpp, sum, satp_mode, satp_ppn, r_pmp,
                            access_w, access_x, va, exp_pa, exp_bad, exp_ar);
                if (n != 13)
                    abort_run("malformed request record in data file");
                {pmp_v, pmp_l, pmp_x, pmp_w, pmp_r} = r_pmp;
                n_req++;
                apply_request();
            end else if (kind == "F") begin
                wait_idle();
                n = $fscanf(fd, "%d %h", r_whole, r_vpn);
                if (n != 2)
                    abort_run("malformed flush record in data file");
                apply_flush(r_whole, r_vpn);
            end else begin
                abort_run($sformatf("unknown record type %s in data file", kind));
            end
        end
        $fclose(fd);

        if (n_req == 0) begin
            abort_run("no requests found in data file");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* hdl/mmu_top.sv */
module mmu_top (
    input  logic             clk,
    input  logic             rstn,
    input  logic             va_valid,
    input  sv32_pkg::vaddr_t va,
    input  logic             access_w,
    input  logic             access_x,
    input  sv32_pkg::prv_t   prv,
    input  logic             mprv,
    input  sv32_pkg::prv_t   mpp,
    input  logic             sum,
    input  logic             satp_mode,
    input  sv32_pkg::ppn_t   satp_ppn,
    input  logic             pmp_v,
    input  logic             pmp_l,
    input  logic             pmp_x,
    input  logic             pmp_w,
    input  logic             pmp_r,
    input  logic             tlb_flush_req,
    input  logic             tlb_flush_all,
    input  sv32_pkg::vpn_t   tlb_flush_vpn,
    output logic             pa_valid,
    output sv32_pkg::paddr_t pa,
    output sv32_pkg::bad_t   pa_bad,
    output logic             busy,
    output logic             m_arvalid,
    output sv32_pkg::paddr_t m_araddr,
    input  logic             m_arready,
    input  logic             m_rvalid,
    input  sv32_pkg::pte_t   m_rdata,
    input  logic [1:0]       m_rresp
);
    import sv32_pkg::*;
    import tlb_pkg::*;

    vpn_t      lookup_vpn;
    vpn_t      refill_vpn;
    pte_t      refill_pte;
    logic      refill_mega;
    logic      tlb_refill;
    pmp_bits_t pmp_now;

    tlb_sel_t  entry_we;
    logic      entry_clear_all;
    logic      entry_clear_vpn;
    tlb_sel_t  entry_match;
    tlb_sel_t  entry_mega;
    pte_t      entry_pte [TLB_ENTRIES];
    pmp_bits_t entry_pmp [TLB_ENTRIES];

    logic      tlb_hit;
    pte_t      hit_pte;
    logic      hit_mega;
    pmp_bits_t hit_pmp;

    assign pmp_now = {pmp_v, pmp_l, pmp_x, pmp_w, pmp_r}; // captured with each refill

    mmu_walker mmu_walker_inst (
        .clk         (clk),
        .rstn        (rstn),
        .va_valid    (va_valid),
        .va          (va),
        .access_w    (access_w),
        .access_x    (access_x),
        .prv         (prv),
        .mprv        (mprv),
        .mpp         (mpp),
        .sum         (sum),
        .satp_mode   (satp_mode),
        .satp_ppn    (satp_ppn),
        .pmp_v       (pmp_v),
        .pmp_l       (pmp_l),
        .pmp_x       (pmp_x),
        .pmp_w       (pmp_w),
        .pmp_r       (pmp_r),
        .tlb_hit     (tlb_hit),
        .hit_pte     (hit_pte),
        .hit_mega    (hit_mega),
        .hit_pmp     (hit_pmp),
        .m_arready   (m_arready),
        .m_rvalid    (m_rvalid),
        .m_rdata     (m_rdata),
        .m_rresp     (m_rresp),
        .pa_valid    (pa_valid),
        .pa          (pa),
        .pa_bad      (pa_bad),
        .busy        (busy),
        .m_arvalid   (m_arvalid),
        .m_araddr    (m_araddr),
        .lookup_vpn  (lookup_vpn),
        .tlb_refill  (tlb_refill),
        .refill_vpn  (refill_vpn),
        .refill_pte  (refill_pte),
        .refill_mega (refill_mega)
    );

    tlb_fill tlb_fill_inst (
        .clk             (clk),
        .rstn            (rstn),
        .tlb_refill      (tlb_refill),
        .tlb_flush_req   (tlb_flush_req),
        .tlb_flush_all   (tlb_flush_all),
        .entry_we        (entry_we),
        .entry_clear_all (entry_clear_all),
        .entry_clear_vpn (entry_clear_vpn)
    );

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        tlb_entry tlb_entry_inst (
            .clk           (clk),
            .rstn          (rstn),
            .we            (entry_we[i]),
            .refill_vpn    (refill_vpn),
            .refill_pte    (refill_pte),
            .refill_mega   (refill_mega),
            .refill_pmp    (pmp_now),
            .lookup_vpn    (lookup_vpn),
            .clear_all     (entry_clear_all),
            .clear_vpn     (entry_clear_vpn),
            .tlb_flush_vpn (tlb_flush_vpn),
            .match         (entry_match[i]),
            .pte           (entry_pte[i]),
            .mega          (entry_mega[i]),
            .pmp           (entry_pmp[i])
        );
    end

    tlb_lookup tlb_lookup_inst (
        .match      (entry_match),
        .entry_pte  (entry_pte),
        .entry_mega (entry_mega),
        .entry_pmp  (entry_pmp),
        .tlb_hit    (tlb_hit),
        .hit_pte    (hit_pte),
        .hit_mega   (hit_mega),
        .hit_pmp    (hit_pmp)
    );

endmodule

/* hdl/mmu_walker.sv */
module mmu_walker (
    input  logic               clk,
    input  logic               rstn,
    input  logic               va_valid,
    input  sv32_pkg::vaddr_t   va,
    input  logic               access_w,
    input  logic               access_x,
    input  sv32_pkg::prv_t     prv,
    input  logic               mprv,
    input  sv32_pkg::prv_t     mpp,
    input  logic               sum,
    input  logic               satp_mode,
    input  sv32_pkg::ppn_t     satp_ppn,
    input  logic               pmp_v,
    input  logic               pmp_l,
    input  logic               pmp_x,
    input  logic               pmp_w,
    input  logic               pmp_r,
    input  logic               tlb_hit,
    input  sv32_pkg::pte_t     hit_pte,
    input  logic               hit_mega,
    input  tlb_pkg::pmp_bits_t hit_pmp,
    input  logic               m_arready,
    input  logic               m_rvalid,
    input  sv32_pkg::pte_t     m_rdata,
    input  logic [1:0]         m_rresp,
    output logic               pa_valid,
    output sv32_pkg::paddr_t   pa,
    output sv32_pkg::bad_t     pa_bad,
    output logic               busy,
    output logic               m_arvalid,
    output sv32_pkg::paddr_t   m_araddr,
    output sv32_pkg::vpn_t     lookup_vpn,
    output logic               tlb_refill,
    output sv32_pkg::vpn_t     refill_vpn,
    output sv32_pkg::pte_t     refill_pte,
    output logic               refill_mega
);
    import sv32_pkg::*;
    import tlb_pkg::*;

    typedef enum logic [1:0] {IDLE, CHECK, MREQ, PTE} walk_state_t;
    typedef logic [$clog2(LEVELS)-1:0] level_t;

    walk_state_t state;
    walk_state_t next_state;
    vaddr_t      va_q;
    prv_t        prv_q;
    prv_t        eff_prv;
    logic        acc_w_q;
    logic        acc_x_q;
    logic        bare_q;
    logic        accept;
    logic        ar_done;
    level_t      level;
    ppn_t        ppn_q;
    pte_t        pte_q;
    logic        bus_err_q;
    logic        pte_leaf;
    logic        pte_fault;
    pmp_bits_t   pmp_now;

    // leaf permission rules, shared by tlb hits and walked ptes
    function automatic logic perm_fault(pte_t p, prv_t pv, logic w, logic x, logic s);
        logic r;
        r = !w && !x;
        return (x && !p[PTE_X]) || (r && !p[PTE_R]) || (w && !p[PTE_W])
            || (pv == PRV_U && !p[PTE_U])
            || (pv == PRV_S && p[PTE_U] && (!s || x))
            || !p[PTE_A]
            || (w && !p[PTE_D]);
    endfunction

    function automatic logic pmp_fault(pmp_bits_t m, prv_t pv, logic w, logic x);
        logic r;
        logic enforce;
        logic deny;
        r       = !w && !x;
        enforce = m[3] || pv != PRV_M; // locked entries bind M mode too
        deny    = (x && !m[2]) || (w && !m[1]) || (r && !m[0]);
        return (!m[4] && pv != PRV_M) || (enforce && deny);
    endfunction

    function automatic paddr_t form_pa(pte_t p, logic mega, vaddr_t v);
        ppn_t ppn;
        ppn = p[PTE_PPN_LSB +: $bits(ppn_t)];
        if (mega)
            ppn[VPN_IDX_W-1:0] = v[PAGE_OFFSET_W +: VPN_IDX_W]; // vpn0 passes through
        return {ppn, v[PAGE_OFFSET_W-1:0]};
    endfunction

    assign eff_prv = (mprv && !access_x) ? mpp : prv;
    assign accept  = va_valid && !busy;
    assign pmp_now = {pmp_v, pmp_l, pmp_x, pmp_w, pmp_r};

    always_ff @(posedge clk) begin
        if (accept) begin
            va_q    <= va;
            prv_q   <= eff_prv;
            acc_w_q <= access_w && !access_x;
            acc_x_q <= access_x;
            bare_q  <= eff_prv == PRV_M || satp_mode == SATP_MODE_BARE;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ar_done <= 1'b0;
            level   <= '0;
        end else begin
            if (m_arvalid && m_arready)
                ar_done <= 1'b1;
            else if (state == MREQ && ar_done && m_rvalid)
                ar_done <= 1'b0;
            if (state == CHECK)
                level <= level_t'(LEVELS - 1);
            else if (state == PTE && !pa_valid)
                level <= level - 1'b1; // pointer, descend
        end
    end

    always_ff @(posedge clk) begin
        if (state == CHECK)
            ppn_q <= satp_ppn;
        else if (state == PTE)
            ppn_q <= pte_q[PTE_PPN_LSB +: $bits(ppn_t)];
        if (state == MREQ && ar_done && m_rvalid) begin
            pte_q     <= m_rdata;
            bus_err_q <= m_rresp[1];
        end
    end

    assign pte_leaf  = pte_q[PTE_V] && (pte_q[PTE_R] || pte_q[PTE_X]);
    assign pte_fault = !pte_q[PTE_V] || (pte_q[PTE_W] && !pte_q[PTE_R])
                     || (!pte_leaf && level == '0)
                     || (pte_leaf && level != '0 && pte_q[PTE_PPN_LSB +: VPN_IDX_W] != '0)
                     || (pte_leaf && perm_fault(pte_q, prv_q, acc_w_q, acc_x_q, sum));

    always_comb begin
        next_state = state;
        case (state)
            CHECK: next_state = (bare_q || tlb_hit) ? IDLE : MREQ;
            MREQ: begin
                if (ar_done && m_rvalid)
                    next_state = PTE;
            end
            PTE: next_state = pa_valid ? IDLE : MREQ;
            default: ;
        endcase
        if (accept)
            next_state = CHECK; // back to back request in the answer cycle
    end

    always_comb begin
        pa_valid   = 1'b0;
        pa         = '0;
        pa_bad     = BAD_NONE;
        tlb_refill = 1'b0;
        case (state)
            CHECK: begin
                if (bare_q) begin
                    pa_valid = 1'b1;
                    pa       = paddr_t'(va_q);
                end else if (tlb_hit) begin
                    pa_valid = 1'b1;
                    if (perm_fault(hit_pte, prv_q, acc_w_q, acc_x_q, sum)) begin
                        pa_bad = BAD_PAGE;
                    end else begin
                        pa = form_pa(hit_pte, hit_mega, va_q);
                        if (pmp_fault(hit_pmp, prv_q, acc_w_q, acc_x_q))
                            pa_bad = BAD_ACCESS; // pmp bits from refill time
                    end
                end
            end
            PTE: begin
                pa_valid = bus_err_q || pte_fault || pte_leaf;
                if (bus_err_q) begin
                    pa_bad = BAD_ACCESS;
                end else if (pte_fault) begin
                    pa_bad = BAD_PAGE;
                end else if (pte_leaf) begin
                    pa         = form_pa(pte_q, level != '0, va_q);
                    tlb_refill = 1'b1;
                    if (pmp_fault(pmp_now, prv_q, acc_w_q, acc_x_q))
                        pa_bad = BAD_ACCESS;
                end
            end
            default: ;
        endcase
    end

    assign busy = state != IDLE && !pa_valid;

    assign lookup_vpn  = va_q[PAGE_OFFSET_W +: $bits(vpn_t)];
    assign refill_vpn  = va_q[PAGE_OFFSET_W +: $bits(vpn_t)];
    assign refill_pte  = pte_q;
    assign refill_mega = level != '0;

    assign m_arvalid = state == MREQ && !ar_done;
    // pte address is ppn * 4096 + index * 4
    assign m_araddr  = {ppn_q, lookup_vpn[VPN_IDX_W*level +: VPN_IDX_W], 2'b00};

endmodule

/* hdl/tlb_lookup.sv */
module tlb_lookup (
    input  tlb_pkg::tlb_sel_t  match,
    input  sv32_pkg::pte_t     entry_pte [tlb_pkg::TLB_ENTRIES],
    input  tlb_pkg::tlb_sel_t  entry_mega,
    input  tlb_pkg::pmp_bits_t entry_pmp [tlb_pkg::TLB_ENTRIES],
    output logic               tlb_hit,
    output sv32_pkg::pte_t     hit_pte,
    output logic               hit_mega,
    output tlb_pkg::pmp_bits_t hit_pmp
);
    import tlb_pkg::*;

    assign tlb_hit = |match;

    // at most one match bit is set, so an or of masked entries selects it
    always_comb begin
        hit_pte  = '0;
        hit_mega = 1'b0;
        hit_pmp  = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit_pte  |= entry_pte[i] & {$bits(hit_pte){match[i]}};
            hit_mega |= entry_mega[i] & match[i];
            hit_pmp  |= entry_pmp[i] & {$bits(hit_pmp){match[i]}};
        end
    end

endmodule

/* hdl/tlb_fill.sv */
module tlb_fill (
    input  logic             clk,
    input  logic             rstn,
    input  logic             tlb_refill,
    input  logic             tlb_flush_req,
    input  logic             tlb_flush_all,
    output tlb_pkg::tlb_sel_t entry_we,
    output logic             entry_clear_all,
    output logic             entry_clear_vpn
);
    import tlb_pkg::*;

    tlb_idx_t victim;
    logic     do_write;

    // a flush wins over a refill in the same cycle
    assign do_write = tlb_refill && !tlb_flush_req;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            victim <= '0;
        end else if (do_write) begin
            if (victim == tlb_idx_t'(TLB_ENTRIES - 1))
                victim <= '0;
            else
                victim <= victim + 1'b1;
        end
    end

    assign entry_we        = do_write ? tlb_sel_t'(1) << victim : '0;
    assign entry_clear_all = tlb_flush_req && tlb_flush_all;
    assign entry_clear_vpn = tlb_flush_req && !tlb_flush_all; // single page, compared per entry

endmodule

/* hdl/tlb_entry.sv */
module tlb_entry (
    input  logic               clk,
    input  logic               rstn,
    input  logic               we,
    input  sv32_pkg::vpn_t     refill_vpn,
    input  sv32_pkg::pte_t     refill_pte,
    input  logic               refill_mega,
    input  tlb_pkg::pmp_bits_t refill_pmp,
    input  sv32_pkg::vpn_t     lookup_vpn,
    input  logic               clear_all,
    input  logic               clear_vpn,
    input  sv32_pkg::vpn_t     tlb_flush_vpn,
    output logic               match,
    output sv32_pkg::pte_t     pte,
    output logic               mega,
    output tlb_pkg::pmp_bits_t pmp
);
    import sv32_pkg::*;
    import tlb_pkg::*;

    logic valid;
    vpn_t tag;
    logic flush_hit;

    function automatic logic covers(vpn_t t, logic m, vpn_t v);
        logic upper_eq;
        upper_eq = t[$bits(vpn_t)-1 -: TLB_MEGA_TAG_W] == v[$bits(vpn_t)-1 -: TLB_MEGA_TAG_W];
        return upper_eq && (m || t[VPN_IDX_W-1:0] == v[VPN_IDX_W-1:0]);
    endfunction

    assign match     = valid && covers(tag, mega, lookup_vpn);
    assign flush_hit = valid && covers(tag, mega, tlb_flush_vpn);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            valid <= 1'b0;
        else if (clear_all || (clear_vpn && flush_hit))
            valid <= 1'b0;
        else if (we)
            valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tag  <= refill_vpn;
            pte  <= refill_pte;
            mega <= refill_mega;
            pmp  <= refill_pmp;
        end
    end

endmodule

/* hdl/tlb_pkg.sv */
package tlb_pkg;

    localparam int TLB_ENTRIES = 8;

    typedef logic [$clog2(TLB_ENTRIES)-1:0] tlb_idx_t;
    typedef logic [TLB_ENTRIES-1:0]         tlb_sel_t;

    // stored pmp set is {v, l, x, w, r}
    localparam int PMP_BITS_W = 5;
    typedef logic [PMP_BITS_W-1:0] pmp_bits_t;

    // a megapage entry only compares the upper vpn index
    localparam int TLB_MEGA_TAG_W = 10;

endpackage

/* hdl/sv32_pkg.sv */
package sv32_pkg;

    localparam int PAGE_OFFSET_W = 12;
    localparam int VPN_IDX_W     = 10; // one level index
    localparam int LEVELS        = 2;

    typedef logic [31:0]              vaddr_t;
    typedef logic [33:0]              paddr_t;
    typedef logic [2*VPN_IDX_W-1:0]   vpn_t;   // {vpn1, vpn0}
    typedef logic [21:0]              ppn_t;
    typedef logic [31:0]              pte_t;
    typedef logic [1:0]               prv_t;

    localparam prv_t PRV_U = 2'd0;
    localparam prv_t PRV_S = 2'd1;
    localparam prv_t PRV_M = 2'd3;

    // pte bit positions
    localparam int PTE_V       = 0;
    localparam int PTE_R       = 1;
    localparam int PTE_W       = 2;
    localparam int PTE_X       = 3;
    localparam int PTE_U       = 4;
    localparam int PTE_G       = 5;
    localparam int PTE_A       = 6;
    localparam int PTE_D       = 7;
    localparam int PTE_PPN_LSB = 10;

    localparam logic SATP_MODE_BARE = 1'b0;

    // bit 0 page fault, bit 1 access fault
    typedef logic [1:0] bad_t;
    localparam bad_t BAD_NONE   = 2'b00;
    localparam bad_t BAD_PAGE   = 2'b01;
    localparam bad_t BAD_ACCESS = 2'b10;

endpackage
